/* bench/bmu_tb.sv */
// Self-checking testbench for the bit-manipulation cluster, run as the simulation top
`timescale 1ns/1ps

module bmu_tb;

  localparam int unsigned SEED       = 32'hf78b_8bc5;
  localparam int          WAIT_MAX   = 40;  // Cycles allowed for any single wait
  localparam int          RST_CYCLES = 8;
  localparam logic [6:0]  OP_R       = bmu_pkg::OPCODE_OP;
  localparam logic [6:0]  OP_I       = bmu_pkg::OPCODE_OPIMM;

  typedef struct {
    string          name;      // Mnemonic, also selects the reference rule
    bmu_pkg::word_t instr;
    bit             imm_form;  // Operand b comes from instr[24:20]
    bit             illegal;   // Expected illegal flag
  } vec_t;

  typedef struct {
    string          label;
    bmu_pkg::word_t instr;
    bmu_pkg::word_t rs1;
    bmu_pkg::word_t rs2;
    bmu_pkg::word_t result;  // Expected
    bit             illegal;
  } job_t;

  logic           clk = 1'b0;
  logic           arst_n;
  logic           issue;
  bmu_pkg::word_t instr;
  bmu_pkg::word_t rs1;
  bmu_pkg::word_t rs2;
  logic           busy;
  logic           result_valid;
  bmu_pkg::word_t result;
  logic           illegal;

  vec_t  table_q[$];   // Stimulus table
  job_t  jobs[$];      // Batch about to be issued
  job_t  pending[$];   // Issued, result still expected, in issue order
  int    errors       = 0;
  int    checks       = 0;
  int    tests_run    = 0;
  int    tests_failed = 0;
  string burst_names [0:9] = '{"clz", "sh1add", "cpop", "ctz", "xnor",
                               "rev8", "cpop", "andn", "clz", "sh3add"};

  always #50 clk = ~clk;  // 100 ns period

  bmu_top dut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .issue_i        (issue),
    .instr_i        (instr),
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .busy_o         (busy),
    .result_valid_o (result_valid),
    .result_o       (result),
    .illegal_o      (illegal)
  );

  ////////////////////////////////////////////////////////////
  // Table and reference model

  // R/I layout, register fields fixed at x10 and x11
  function automatic bmu_pkg::word_t encode(input logic [6:0] opcode, input logic [6:0] funct7,
                                            input logic [4:0] rs2f, input logic [2:0] funct3);
    return {funct7, rs2f, 5'd10, funct3, 5'd11, opcode};
  endfunction

  task automatic add_vec(input string name, input bmu_pkg::word_t word, input bit imm_form,
                         input bit bad);
    vec_t v;
    v.name     = name;
    v.instr    = word;
    v.imm_form = imm_form;
    v.illegal  = bad;
    table_q.push_back(v);
  endtask

  task automatic build_table();
    add_vec("sh1add", encode(OP_R, 7'b0010000, 5'd2, 3'b010), 0, 0);  // Zba
    add_vec("sh2add", encode(OP_R, 7'b0010000, 5'd2, 3'b100), 0, 0);
    add_vec("sh3add", encode(OP_R, 7'b0010000, 5'd2, 3'b110), 0, 0);
    add_vec("min",    encode(OP_R, 7'b0000101, 5'd2, 3'b100), 0, 0);  // Zbb
    add_vec("minu",   encode(OP_R, 7'b0000101, 5'd2, 3'b101), 0, 0);
    add_vec("bad_funct7", encode(OP_R, 7'b1111111, 5'd2, 3'b001), 0, 1);
    add_vec("max",    encode(OP_R, 7'b0000101, 5'd2, 3'b110), 0, 0);
    add_vec("maxu",   encode(OP_R, 7'b0000101, 5'd2, 3'b111), 0, 0);
    add_vec("andn",   encode(OP_R, 7'b0100000, 5'd2, 3'b111), 0, 0);
    add_vec("orn",    encode(OP_R, 7'b0100000, 5'd2, 3'b110), 0, 0);
    add_vec("xnor",   encode(OP_R, 7'b0100000, 5'd2, 3'b100), 0, 0);
    add_vec("mul_funct7", encode(OP_R, 7'b0000001, 5'd2, 3'b000), 0, 1);  // M, not B
    add_vec("rol",    encode(OP_R, 7'b0110000, 5'd2, 3'b001), 0, 0);
    add_vec("ror",    encode(OP_R, 7'b0110000, 5'd2, 3'b101), 0, 0);
    add_vec("bset",   encode(OP_R, 7'b0010100, 5'd2, 3'b001), 0, 0);  // Zbs
    add_vec("bclr",   encode(OP_R, 7'b0100100, 5'd2, 3'b001), 0, 0);
    add_vec("binv",   encode(OP_R, 7'b0110100, 5'd2, 3'b001), 0, 0);
    add_vec("bext",   encode(OP_R, 7'b0100100, 5'd2, 3'b101), 0, 0);
    add_vec("wrong_opcode", encode(7'h3b, 7'b0010000, 5'd2, 3'b010), 0, 1);
    add_vec("clz",    encode(OP_I, 7'b0110000, 5'b00000, 3'b001), 1, 0);  // Unary
    add_vec("ctz",    encode(OP_I, 7'b0110000, 5'b00001, 3'b001), 1, 0);
    add_vec("cpop",   encode(OP_I, 7'b0110000, 5'b00010, 3'b001), 1, 0);
    add_vec("sext.b", encode(OP_I, 7'b0110000, 5'b00100, 3'b001), 1, 0);
    add_vec("sext.h", encode(OP_I, 7'b0110000, 5'b00101, 3'b001), 1, 0);
    add_vec("orc.b",  encode(OP_I, 7'b0010100, 5'b00111, 3'b101), 1, 0);
    add_vec("rev8",   encode(OP_I, 7'b0110100, 5'b11000, 3'b101), 1, 0);
    add_vec("clz_bad_rs2", encode(OP_I, 7'b0110000, 5'b10000, 3'b001), 1, 1);
    add_vec("rori",   encode(OP_I, 7'b0110000, 5'd13, 3'b101), 1, 0);  // Shift amount forms
    add_vec("bseti",  encode(OP_I, 7'b0010100, 5'd31, 3'b001), 1, 0);
    add_vec("bclri",  encode(OP_I, 7'b0100100, 5'd7,  3'b001), 1, 0);
    add_vec("binvi",  encode(OP_I, 7'b0110100, 5'd20, 3'b001), 1, 0);
    add_vec("bexti",  encode(OP_I, 7'b0100100, 5'd5,  3'b101), 1, 0);
  endtask

  function automatic int find_vec(input string name);
    for (int k = 0; k < table_q.size(); k++) begin
      if (table_q[k].name == name) return k;
    end
    return 0;
  endfunction

  // Expected result from the operator rules, b already holds the immediate for I forms
  function automatic bmu_pkg::word_t ref_result(input string name, input bmu_pkg::word_t a,
                                                input bmu_pkg::word_t b);
    bmu_pkg::word_t r;
    int             sh;
    int             n;
    sh = int'(b[4:0]);
    r  = '0;
    n  = 0;
    case (name)
      "sh1add":        r = (a << 1) + b;
      "sh2add":        r = (a << 2) + b;
      "sh3add":        r = (a << 3) + b;
      "min":           r = ($signed(a) < $signed(b)) ? a : b;
      "minu":          r = (a < b) ? a : b;
      "max":           r = ($signed(a) > $signed(b)) ? a : b;
      "maxu":          r = (a > b) ? a : b;
      "andn":          r = a & ~b;
      "orn":           r = a | ~b;
      "xnor":          r = ~(a ^ b);
      "rol":           r = (a << sh) | (a >> (32 - sh));  // Shift by 32 gives zero
      "ror", "rori":   r = (a >> sh) | (a << (32 - sh));
      "clz": begin
        for (int i = 31; i >= 0; i--) begin
          if (a[i]) break;
          n++;
        end
        r = bmu_pkg::word_t'(n);
      end
      "ctz": begin
        for (int i = 0; i < 32; i++) begin
          if (a[i]) break;
          n++;
        end
        r = bmu_pkg::word_t'(n);
      end
      "cpop":          r = bmu_pkg::word_t'($countones(a));
      "orc.b": begin
        for (int k = 0; k < 4; k++) begin
          r[8*k +: 8] = (a[8*k +: 8] != 8'h00) ? 8'hff : 8'h00;
        end
      end
      "rev8":          r = {<<8{a}};
      "sext.b":        r = {{24{a[7]}}, a[7:0]};
      "sext.h":        r = {{16{a[15]}}, a[15:0]};
      "bset", "bseti": r = a | (32'h1 << sh);
      "bclr", "bclri": r = a & ~(32'h1 << sh);
      "binv", "binvi": r = a ^ (32'h1 << sh);
      "bext", "bexti": r = (a >> sh) & 32'h1;
      default:         r = '0;
    endcase
    return r;
  endfunction

  function automatic job_t make_job(input int idx, input bmu_pkg::word_t a,
                                    input bmu_pkg::word_t b_reg);
    job_t           j;
    vec_t           v;
    bmu_pkg::word_t b;
    v       = table_q[idx];
    j.label = v.name;
    j.instr = v.instr;
    j.rs1   = a;
    j.rs2   = b_reg;
    b       = b_reg;
    if (v.imm_form) begin
      j.rs2 = {b_reg[31:5], ~v.instr[24:20]};  // Low bits never equal the immediate
      b     = {27'b0, v.instr[24:20]};
    end
    j.illegal = v.illegal;
    j.result  = v.illegal ? '0 : ref_result(v.name, a, b);
    return j;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks and reporting

  task automatic check_value(input string sig, input bmu_pkg::word_t got,
                             input bmu_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH time=%0t %s got=%08h expected=%08h", $time, sig, got, exp);
    end
  endtask

  task automatic report_test(input string label, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %-22s failed", label);
    end else begin
      $display("test %-22s ok", label);
    end
  endtask

  // Polls busy on falling edges, caller sits on a falling edge
  task automatic wait_ready(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < WAIT_MAX; n++) begin
      if (!busy) begin
        ok = 1'b1;
        break;
      end
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Issue and collect

  task automatic issue_jobs(input bit expect_free);
    bit ok;
    for (int k = 0; k < jobs.size(); k++) begin
      issue = 1'b0;
      if (expect_free && (k < bmu_pkg::BMU_NUM_LANES)) begin
        check_value("busy_o", bmu_pkg::word_t'(busy), '0);  // Free lane expected
      end
      wait_ready(ok);
      if (!ok) begin
        $display("Timeout: busy_o stayed high, %s was never issued", jobs[k].label);
        errors++;
        break;
      end
      issue = 1'b1;
      instr = jobs[k].instr;
      rs1   = jobs[k].rs1;
      rs2   = jobs[k].rs2;
      pending.push_back(jobs[k]);
      @(negedge clk);
    end
    issue = 1'b0;
  endtask

  task automatic collect_results(input int count);
    job_t j;
    bit   found;
    int   err_before;
    for (int k = 0; k < count; k++) begin
      found = 1'b0;
      for (int n = 0; n < WAIT_MAX; n++) begin
        @(negedge clk);
        if (result_valid) begin
          found = 1'b1;
          break;
        end
      end
      if (!found) begin
        $display("Timeout: result %0d of %0d never arrived", k + 1, count);
        errors++;
        break;
      end
      if (pending.size() == 0) begin
        $display("Result arrived with no instruction outstanding at time %0t", $time);
        errors++;
        continue;
      end
      j          = pending.pop_front();  // Oldest first
      err_before = errors;
      check_value({j.label, " result_o"}, result, j.result);
      check_value({j.label, " illegal_o"}, bmu_pkg::word_t'(illegal),
                  bmu_pkg::word_t'(j.illegal));
      report_test(j.label, err_before);
    end
  endtask

  task automatic run_batch(input bit expect_free);
    int count;
    count = jobs.size();
    pending.delete();
    fork
      issue_jobs(expect_free);
      collect_results(count);
    join
    if (pending.size() != 0) begin
      $display("%0d issued instructions produced no result", pending.size());
      errors++;
    end
  endtask

  // Lone instruction, counts rising edges after the issue edge up to the valid pulse
  task automatic latency_test(input job_t j, input int exp_edges);
    int edges;
    bit found;
    bit ok;
    int err_before;
    err_before = errors;
    edges      = 0;
    found      = 1'b0;
    wait_ready(ok);
    if (ok) begin
      issue = 1'b1;
      instr = j.instr;
      rs1   = j.rs1;
      rs2   = j.rs2;
      @(negedge clk);  // Issue edge has passed
      issue = 1'b0;
      for (int n = 0; n < WAIT_MAX; n++) begin
        @(posedge clk);
        edges++;
        @(negedge clk);
        if (result_valid) begin
          found = 1'b1;
          break;
        end
      end
    end
    if (!ok) begin
      $display("Timeout: busy_o stayed high, single %s was never issued", j.label);
      errors++;
    end else if (found) begin
      check_value({j.label, " latency"}, bmu_pkg::word_t'(edges), bmu_pkg::word_t'(exp_edges));
      check_value({j.label, " result_o"}, result, j.result);
      check_value({j.label, " illegal_o"}, bmu_pkg::word_t'(illegal), '0);
    end else begin
      $display("Timeout: single %s gave no result", j.label);
      errors++;
    end
    report_test({"latency ", j.label}, err_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence

  initial begin : main
    int             err_before;
    job_t           j;
    bmu_pkg::word_t a;
    arst_n   = 1'b0;
    issue    = 1'b0;
    instr    = '0;
    rs1      = '0;
    rs2      = '0;
    void'($urandom(SEED));
    build_table();

    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Idle outputs right after reset
    err_before = errors;
    check_value("busy_o", bmu_pkg::word_t'(busy), '0);
    check_value("result_valid_o", bmu_pkg::word_t'(result_valid), '0);
    @(negedge clk);
    check_value("result_valid_o", bmu_pkg::word_t'(result_valid), '0);
    report_test("reset", err_before);

    latency_test(make_job(find_vec("sh2add"), $urandom, $urandom), 2);
    latency_test(make_job(find_vec("cpop"), $urandom, $urandom), 3);

    // Whole table, illegal words sit between legal neighbours
    jobs.delete();
    for (int k = 0; k < table_q.size(); k++) begin
      jobs.push_back(make_job(k, $urandom, $urandom));
    end
    run_batch(1'b0);

    // Back-to-back count and plain mix, some operands zero
    jobs.delete();
    for (int k = 0; k < 10; k++) begin
      a       = (k % 3 == 0) ? 32'h0 : $urandom;
      j       = make_job(find_vec(burst_names[k]), a, $urandom);
      j.label = {"burst ", j.label};
      jobs.push_back(j);
    end
    run_batch(1'b1);

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if ((errors == 0) && (tests_failed == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* build.f */
logic/bmu_pkg.sv
logic/bmu_b_decoder.sv
logic/bmu_alu.sv
logic/bmu_lane.sv
logic/bmu_dispatch.sv
logic/bmu_retire.sv
logic/bmu_top.sv
bench/bmu_tb.sv

/* logic/bmu_alu.sv */
// Combinational bit-manipulation ALU, one result per operator
`timescale 1ns/1ps

module bmu_alu (
  input  bmu_pkg::alu_op_e operator_i,
  input  bmu_pkg::word_t   op_a_i,
  input  bmu_pkg::word_t   op_b_i,
  output bmu_pkg::word_t   result_o
);

  logic [4:0]     shamt;     // Rotate amount and bit index
  bmu_pkg::word_t bit_mask;  // One-hot at shamt
  logic [63:0]    rol_full;
  logic [63:0]    ror_full;
  logic [5:0]     clz_cnt;
  logic [5:0]     ctz_cnt;
  logic [5:0]     cpop_cnt;
  bmu_pkg::word_t orc_b;

  assign shamt    = op_b_i[4:0];
  assign bit_mask = bmu_pkg::word_t'(1) << shamt;
  assign rol_full = {op_a_i, op_a_i} << shamt;  // Upper half is the rotate
  assign ror_full = {op_a_i, op_a_i} >> shamt;  // Lower half is the rotate

  ////////////////////////////////////////////////////////////
  // Counts, the slow path

  always_comb begin : counts
    clz_cnt  = 6'd32;  // All-zero input counts 32
    ctz_cnt  = 6'd32;
    cpop_cnt = '0;
    for (int i = 0; i < 32; i++) begin
      if (op_a_i[i]) begin
        clz_cnt  = 6'(31 - i);  // Last hit is the highest set bit
        cpop_cnt = cpop_cnt + 6'd1;
      end
      if (op_a_i[31 - i]) begin
        ctz_cnt = 6'(31 - i);   // Last hit is the lowest set bit
      end
    end
  end

  // OR-combine within each byte
  always_comb begin : byte_or
    for (int b = 0; b < 4; b++) begin
      orc_b[8*b +: 8] = {8{|op_a_i[8*b +: 8]}};
    end
  end

  ////////////////////////////////////////////////////////////
  // Result select

  always_comb begin : result_mux
    case (operator_i)
      bmu_pkg::ALU_B_SH1ADD: result_o = {op_a_i[30:0], 1'b0} + op_b_i;
      bmu_pkg::ALU_B_SH2ADD: result_o = {op_a_i[29:0], 2'b0} + op_b_i;
      bmu_pkg::ALU_B_SH3ADD: result_o = {op_a_i[28:0], 3'b0} + op_b_i;
      bmu_pkg::ALU_B_MIN:    result_o = ($signed(op_a_i) < $signed(op_b_i)) ? op_a_i : op_b_i;
      bmu_pkg::ALU_B_MINU:   result_o = (op_a_i < op_b_i) ? op_a_i : op_b_i;
      bmu_pkg::ALU_B_MAX:    result_o = ($signed(op_a_i) < $signed(op_b_i)) ? op_b_i : op_a_i;
      bmu_pkg::ALU_B_MAXU:   result_o = (op_a_i < op_b_i) ? op_b_i : op_a_i;
      bmu_pkg::ALU_B_ANDN:   result_o = op_a_i & ~op_b_i;
      bmu_pkg::ALU_B_ORN:    result_o = op_a_i | ~op_b_i;
      bmu_pkg::ALU_B_XNOR:   result_o = ~(op_a_i ^ op_b_i);
      bmu_pkg::ALU_B_ROL:    result_o = rol_full[63:32];
      bmu_pkg::ALU_B_ROR:    result_o = ror_full[31:0];
      bmu_pkg::ALU_B_CLZ:    result_o = bmu_pkg::word_t'(clz_cnt);
      bmu_pkg::ALU_B_CTZ:    result_o = bmu_pkg::word_t'(ctz_cnt);
      bmu_pkg::ALU_B_CPOP:   result_o = bmu_pkg::word_t'(cpop_cnt);
      bmu_pkg::ALU_B_ORC_B:  result_o = orc_b;
      bmu_pkg::ALU_B_REV8:   result_o = {op_a_i[7:0], op_a_i[15:8], op_a_i[23:16], op_a_i[31:24]};
      bmu_pkg::ALU_B_SEXT_B: result_o = {{24{op_a_i[7]}}, op_a_i[7:0]};
      bmu_pkg::ALU_B_SEXT_H: result_o = {{16{op_a_i[15]}}, op_a_i[15:0]};
      bmu_pkg::ALU_B_BSET:   result_o = op_a_i | bit_mask;
      bmu_pkg::ALU_B_BCLR:   result_o = op_a_i & ~bit_mask;
      bmu_pkg::ALU_B_BINV:   result_o = op_a_i ^ bit_mask;
      bmu_pkg::ALU_B_BEXT:   result_o = {31'b0, op_a_i[shamt]};
      default:               result_o = '0;  // NOP, illegal word
    endcase
  end

endmodule

/* logic/bmu_b_decoder.sv */
// Combinational B-extension decoder, maps an instruction word to an ALU operator
`timescale 1ns/1ps

module bmu_b_decoder #(
  parameter bmu_pkg::b_ext_e B_EXT = bmu_pkg::NONE
) (
  input  bmu_pkg::word_t   instr_rdata_i,
  output bmu_pkg::alu_op_e alu_operator_o,
  output logic             op_b_imm_o,     // Operand b from instr[24:20]
  output logic             illegal_insn_o
);

  // Group enables from the configured subset
  localparam bit RV32B_ZBA = (B_EXT == bmu_pkg::ZBA_ZBB_ZBS) ||
                             (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);
  localparam bit RV32B_ZBB = (B_EXT == bmu_pkg::ZBA_ZBB_ZBS) ||
                             (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);
  localparam bit RV32B_ZBS = (B_EXT == bmu_pkg::ZBA_ZBB_ZBS) ||
                             (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);

  bmu_pkg::alu_op_e op_sel;  // Raw match, before the group enable
  logic             grp_en;  // Matched group is built in
  logic             is_imm;

  assign is_imm = (instr_rdata_i[6:0] == bmu_pkg::OPCODE_OPIMM);

  always_comb begin : match
    op_sel = bmu_pkg::ALU_NOP;
    case (instr_rdata_i[6:0])
      bmu_pkg::OPCODE_OP: begin
        // Key is funct7, funct3
        case ({instr_rdata_i[31:25], instr_rdata_i[14:12]})
          {7'b001_0000, 3'b010}: op_sel = bmu_pkg::ALU_B_SH1ADD;  // sh1add
          {7'b001_0000, 3'b100}: op_sel = bmu_pkg::ALU_B_SH2ADD;  // sh2add
          {7'b001_0000, 3'b110}: op_sel = bmu_pkg::ALU_B_SH3ADD;  // sh3add
          {7'b000_0101, 3'b100}: op_sel = bmu_pkg::ALU_B_MIN;     // min
          {7'b000_0101, 3'b101}: op_sel = bmu_pkg::ALU_B_MINU;    // minu
          {7'b000_0101, 3'b110}: op_sel = bmu_pkg::ALU_B_MAX;     // max
          {7'b000_0101, 3'b111}: op_sel = bmu_pkg::ALU_B_MAXU;    // maxu
          {7'b010_0000, 3'b111}: op_sel = bmu_pkg::ALU_B_ANDN;    // andn
          {7'b010_0000, 3'b110}: op_sel = bmu_pkg::ALU_B_ORN;     // orn
          {7'b010_0000, 3'b100}: op_sel = bmu_pkg::ALU_B_XNOR;    // xnor
          {7'b011_0000, 3'b001}: op_sel = bmu_pkg::ALU_B_ROL;     // rol
          {7'b011_0000, 3'b101}: op_sel = bmu_pkg::ALU_B_ROR;     // ror
          {7'b001_0100, 3'b001}: op_sel = bmu_pkg::ALU_B_BSET;    // bset
          {7'b010_0100, 3'b001}: op_sel = bmu_pkg::ALU_B_BCLR;    // bclr
          {7'b011_0100, 3'b001}: op_sel = bmu_pkg::ALU_B_BINV;    // binv
          {7'b010_0100, 3'b101}: op_sel = bmu_pkg::ALU_B_BEXT;    // bext
          default:               op_sel = bmu_pkg::ALU_NOP;
        endcase
      end
      bmu_pkg::OPCODE_OPIMM: begin
        // Key is funct7, rs2 field, funct3; shift-amount forms leave rs2 free
        casez ({instr_rdata_i[31:25], instr_rdata_i[24:20], instr_rdata_i[14:12]})
          {7'b011_0000, 5'b0_0000, 3'b001}: op_sel = bmu_pkg::ALU_B_CLZ;     // clz
          {7'b011_0000, 5'b0_0001, 3'b001}: op_sel = bmu_pkg::ALU_B_CTZ;     // ctz
          {7'b011_0000, 5'b0_0010, 3'b001}: op_sel = bmu_pkg::ALU_B_CPOP;    // cpop
          {7'b001_0100, 5'b0_0111, 3'b101}: op_sel = bmu_pkg::ALU_B_ORC_B;   // orc.b
          {7'b011_0100, 5'b1_1000, 3'b101}: op_sel = bmu_pkg::ALU_B_REV8;    // rev8
          {7'b011_0000, 5'b0_0100, 3'b001}: op_sel = bmu_pkg::ALU_B_SEXT_B;  // sext.b
          {7'b011_0000, 5'b0_0101, 3'b001}: op_sel = bmu_pkg::ALU_B_SEXT_H;  // sext.h
          {7'b011_0000, 5'b?_????, 3'b101}: op_sel = bmu_pkg::ALU_B_ROR;     // rori
          {7'b001_0100, 5'b?_????, 3'b001}: op_sel = bmu_pkg::ALU_B_BSET;    // bseti
          {7'b010_0100, 5'b?_????, 3'b001}: op_sel = bmu_pkg::ALU_B_BCLR;    // bclri
          {7'b011_0100, 5'b?_????, 3'b001}: op_sel = bmu_pkg::ALU_B_BINV;    // binvi
          {7'b010_0100, 5'b?_????, 3'b101}: op_sel = bmu_pkg::ALU_B_BEXT;    // bexti
          default:                          op_sel = bmu_pkg::ALU_NOP;
        endcase
      end
      default: op_sel = bmu_pkg::ALU_NOP;  // Not a B opcode
    endcase
  end

  // Which extension owns the matched operator
  always_comb begin : group
    case (op_sel)
      bmu_pkg::ALU_NOP:      grp_en = 1'b0;
      bmu_pkg::ALU_B_SH1ADD,
      bmu_pkg::ALU_B_SH2ADD,
      bmu_pkg::ALU_B_SH3ADD: grp_en = RV32B_ZBA;
      bmu_pkg::ALU_B_BSET,
      bmu_pkg::ALU_B_BCLR,
      bmu_pkg::ALU_B_BINV,
      bmu_pkg::ALU_B_BEXT:   grp_en = RV32B_ZBS;
      default:               grp_en = RV32B_ZBB;
    endcase
  end

  assign alu_operator_o = grp_en ? op_sel : bmu_pkg::ALU_NOP;
  assign illegal_insn_o = !grp_en;
  // Unary ops also select the immediate, the ALU ignores operand b for them
  assign op_b_imm_o     = grp_en && is_imm;

endmodule

/* logic/bmu_dispatch.sv */
// Round-robin dispatcher, strobes the next free lane and reports when it is still occupied
`timescale 1ns/1ps

module bmu_dispatch (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                issue_i,
  input  logic [bmu_pkg::BMU_NUM_LANES-1:0]   lane_busy_i,
  output logic [bmu_pkg::BMU_NUM_LANES-1:0]   load_o,
  output logic                                busy_o
);

  bmu_pkg::lane_idx_t ptr_q;     // Next lane to fill
  logic               issue_ok;  // Issue accepted

  assign busy_o   = lane_busy_i[ptr_q];
  assign issue_ok = issue_i && !busy_o;

  // One-hot load into the lane under the pointer
  always_comb begin
    load_o        = '0;
    load_o[ptr_q] = issue_ok;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (issue_ok) begin
      ptr_q <= (ptr_q == bmu_pkg::lane_idx_t'(bmu_pkg::BMU_NUM_LANES - 1)) ? '0 : ptr_q + 1'b1;
    end
  end

endmodule

/* logic/bmu_lane.sv */
// One execution lane, holds an instruction from load through decode and ALU until release
`timescale 1ns/1ps

module bmu_lane #(
  parameter bmu_pkg::b_ext_e B_EXT = bmu_pkg::NONE
) (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           load_i,     // Strobe from dispatch
  input  bmu_pkg::word_t instr_i,
  input  bmu_pkg::word_t rs1_i,
  input  bmu_pkg::word_t rs2_i,
  input  logic           release_i,  // Retire has taken the result
  output logic           busy_o,
  output logic           done_o,
  output logic           illegal_o,
  output bmu_pkg::word_t result_o
);

  typedef enum logic [1:0] {
    IDLE,   // Free for a load
    EXEC,   // Operands registered, ALU working
    COUNT,  // Second cycle for clz, ctz, cpop
    DONE    // Result held for retire
  } lane_state_e;

  lane_state_e      state_q;
  bmu_pkg::word_t   instr_q;
  bmu_pkg::word_t   rs1_q;
  bmu_pkg::word_t   rs2_q;
  bmu_pkg::word_t   op_b;
  bmu_pkg::word_t   alu_result;
  bmu_pkg::alu_op_e alu_op;
  logic             op_b_imm;
  logic             dec_illegal;
  logic             is_count;
  logic             capture;  // Write result register this cycle

  bmu_b_decoder #(
    .B_EXT (B_EXT)
  ) u_decoder (
    .instr_rdata_i  (instr_q),
    .alu_operator_o (alu_op),
    .op_b_imm_o     (op_b_imm),
    .illegal_insn_o (dec_illegal)
  );

  assign op_b = op_b_imm ? {27'b0, instr_q[24:20]} : rs2_q;  // shamt or rs2

  bmu_alu u_alu (
    .operator_i (alu_op),
    .op_a_i     (rs1_q),
    .op_b_i     (op_b),
    .result_o   (alu_result)
  );

  assign is_count = alu_op inside {bmu_pkg::ALU_B_CLZ, bmu_pkg::ALU_B_CTZ, bmu_pkg::ALU_B_CPOP};
  // Count ops get two cycles through the ALU before capture
  assign capture  = ((state_q == EXEC) && !is_count) || (state_q == COUNT);

  ////////////////////////////////////////////////////////////
  // Control

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (load_i) state_q <= EXEC;
        EXEC:    state_q <= is_count ? COUNT : DONE;
        COUNT:   state_q <= DONE;
        DONE:    if (release_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Operand and result registers
  always_ff @(posedge clk_i) begin
    if (load_i && (state_q == IDLE)) begin  // Load while busy is dropped
      instr_q <= instr_i;
      rs1_q   <= rs1_i;
      rs2_q   <= rs2_i;
    end
    if (capture) begin
      result_o  <= alu_result;
      illegal_o <= dec_illegal;  // NOP already forces zero
    end
  end

  assign busy_o = (state_q != IDLE);  // Load to release
  assign done_o = (state_q == DONE);

endmodule

/* logic/bmu_pkg.sv */
// Shared types, lane count, opcodes and extension subset for the bit-manipulation cluster
package bmu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths

  typedef logic [31:0] word_t;      // Instruction, operand and result word
  typedef logic [1:0]  lane_idx_t;  // Selects one of the lanes

  localparam int unsigned BMU_NUM_LANES = 4;  // Max instructions in flight

  ////////////////////////////////////////////////////////////
  // Extension subset

  typedef enum logic [1:0] {
    NONE,             // No B instructions, every word is illegal
    ZBA_ZBB_ZBS,
    ZBA_ZBB_ZBC_ZBS   // Zbc carries no instructions of its own here
  } b_ext_e;

  localparam b_ext_e BMU_B_EXT = ZBA_ZBB_ZBS;  // Subset built into the cluster

  ////////////////////////////////////////////////////////////
  // ALU operators

  typedef enum logic [4:0] {
    ALU_NOP,        // Unsupported word, result is zero
    ALU_B_SH1ADD,   // Zba
    ALU_B_SH2ADD,
    ALU_B_SH3ADD,
    ALU_B_MIN,      // Zbb
    ALU_B_MINU,
    ALU_B_MAX,
    ALU_B_MAXU,
    ALU_B_ANDN,
    ALU_B_ORN,
    ALU_B_XNOR,
    ALU_B_ROL,
    ALU_B_ROR,
    ALU_B_CLZ,      // Count ops take the slow lane path
    ALU_B_CTZ,
    ALU_B_CPOP,
    ALU_B_ORC_B,
    ALU_B_REV8,
    ALU_B_SEXT_B,
    ALU_B_SEXT_H,
    ALU_B_BSET,     // Zbs
    ALU_B_BCLR,
    ALU_B_BINV,
    ALU_B_BEXT
  } alu_op_e;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPCODE_OP    = 7'h33;  // Register form
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;  // Immediate form

endpackage

/* logic/bmu_retire.sv */
// In-order retire, takes finished lane results in issue order and registers the output
`timescale 1ns/1ps

module bmu_retire (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,
  input  logic [bmu_pkg::BMU_NUM_LANES-1:0]                      lane_done_i,
  input  bmu_pkg::word_t [bmu_pkg::BMU_NUM_LANES-1:0]            lane_result_i,
  input  logic [bmu_pkg::BMU_NUM_LANES-1:0]                      lane_illegal_i,
  output logic [bmu_pkg::BMU_NUM_LANES-1:0]                      release_o,
  output logic                                                   result_valid_o,
  output logic                                                   illegal_o,
  output bmu_pkg::word_t                                         result_o
);

  bmu_pkg::lane_idx_t ptr_q;  // Oldest instruction in flight
  logic               take;   // Oldest lane has finished

  assign take = lane_done_i[ptr_q];  // Younger done lanes wait their turn

  always_comb begin
    release_o        = '0;
    release_o[ptr_q] = take;
  end

  ////////////////////////////////////////////////////////////
  // Pointer and valid pulse

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q          <= '0;
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= take;  // One pulse per release
      if (take) begin
        ptr_q <= (ptr_q == bmu_pkg::lane_idx_t'(bmu_pkg::BMU_NUM_LANES - 1)) ? '0 : ptr_q + 1'b1;
      end
    end
  end

  // Output payload, sampled on the release edge
  always_ff @(posedge clk_i) begin
    if (take) begin
      result_o  <= lane_result_i[ptr_q];
      illegal_o <= lane_illegal_i[ptr_q];
    end
  end

endmodule

/* logic/bmu_top.sv */
// Top of the bit-manipulation cluster, dispatcher feeding four lanes and an in-order retire
`timescale 1ns/1ps

module bmu_top (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           issue_i,         // One-cycle strobe
  input  bmu_pkg::word_t instr_i,
  input  bmu_pkg::word_t rs1_i,
  input  bmu_pkg::word_t rs2_i,
  output logic           busy_o,          // Next lane still occupied
  output logic           result_valid_o,  // One-cycle pulse
  output bmu_pkg::word_t result_o,
  output logic           illegal_o
);

  logic [bmu_pkg::BMU_NUM_LANES-1:0]           lane_load;
  logic [bmu_pkg::BMU_NUM_LANES-1:0]           lane_busy;
  logic [bmu_pkg::BMU_NUM_LANES-1:0]           lane_done;
  logic [bmu_pkg::BMU_NUM_LANES-1:0]           lane_illegal;
  logic [bmu_pkg::BMU_NUM_LANES-1:0]           lane_release;
  bmu_pkg::word_t [bmu_pkg::BMU_NUM_LANES-1:0] lane_result;

  bmu_dispatch u_dispatch (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .issue_i     (issue_i),
    .lane_busy_i (lane_busy),
    .load_o      (lane_load),
    .busy_o      (busy_o)
  );

  ////////////////////////////////////////////////////////////
  // Lanes, operand buses shared

  for (genvar g = 0; g < bmu_pkg::BMU_NUM_LANES; g++) begin : g_lane
    bmu_lane #(
      .B_EXT (bmu_pkg::BMU_B_EXT)
    ) u_lane (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .load_i    (lane_load[g]),
      .instr_i   (instr_i),
      .rs1_i     (rs1_i),
      .rs2_i     (rs2_i),
      .release_i (lane_release[g]),
      .busy_o    (lane_busy[g]),
      .done_o    (lane_done[g]),
      .illegal_o (lane_illegal[g]),
      .result_o  (lane_result[g])
    );
  end

  bmu_retire u_retire (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .lane_done_i    (lane_done),
    .lane_result_i  (lane_result),
    .lane_illegal_i (lane_illegal),
    .release_o      (lane_release),
    .result_valid_o (result_valid_o),
    .illegal_o      (illegal_o),
    .result_o       (result_o)
  );

endmodule

/* run.sh */
#!/bin/sh
# Build the cluster testbench with Verilator, run it, and scan the log for a failure
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module bmu_tb -f build.f -o bmu_sim
./obj_dir/bmu_sim > sim.log
cat sim.log

if grep -qF "** FAIL **" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
